/* hdl/graph_cu_pkg.sv */
/*
 * Graph compute unit definitions
 * Read command opcodes, abort modes, sequencer states, the
 * datapath widths and the configuration field positions shared
 * by the edge-data read stage
 */

package graph_cu_pkg;

	// Read command opcodes
	typedef enum logic [1:0] {
		READ_CL_S  = 2'd0,
		READ_CL_NA = 2'd1
	} cmd_opcode_t;

	// Abort modes carried with every command
	typedef enum logic [2:0] {
		ABT_STRICT = 3'd0,
		ABT_ABORT  = 3'd1,
		ABT_PAGE   = 3'd2,
		ABT_PREF   = 3'd3,
		ABT_SPEC   = 3'd4
	} abort_type_t;

	// Enable sequencer
	typedef enum logic [1:0] {
		CU_DISABLED    = 2'd0,
		CU_WAIT_CONFIG = 2'd1,
		CU_ACTIVE      = 2'd2
	} cu_state_t;

	// One read command fetches a full cache line
	localparam int CACHELINE_BYTES = 128;
	localparam int CL_OFFSET_W     = $clog2(CACHELINE_BYTES);

	localparam int ADDR_W   = 64;
	localparam int VERTEX_W = 32;
	localparam int DATA_W   = 32;
	localparam int CFG_W    = 64;

	// Configuration word fields
	localparam int CFG_ABT_LSB    = 10;
	localparam int CFG_SHARED_BIT = 13;

	// Unknown codes fall back to strict ordering
	function automatic abort_type_t map_abort(input logic [2:0] code);
		abort_type_t abt;
		case (code)
			3'd0:    abt = ABT_STRICT;
			3'd1:    abt = ABT_ABORT;
			3'd2:    abt = ABT_PAGE;
			3'd3:    abt = ABT_PREF;
			3'd4:    abt = ABT_SPEC;
			default: abt = ABT_STRICT;
		endcase
		return abt;
	endfunction

endpackage

/* hdl/edge_fifo.sv */
/*
 * Edge FIFO
 * Circular buffer with registered output and an occupancy count.
 * valid strobes the cycle after an accepted pop, alfull warns at
 * two entries short of full
 */

`timescale 1ns/100ps

module edge_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             valid,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);
	localparam logic [CNT_W-1:0] ALFULL_CNT = CNT_W'(DEPTH - 2);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full   = (count == FULL_CNT);
	assign alfull = (count >= ALFULL_CNT);
	assign empty  = (count == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			valid  <= 1'b0;
		end else begin
			valid <= do_pop;
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage and read port
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
		if (do_pop)
			data_out <= mem[rd_ptr];
	end

endmodule

/* hdl/cu_enable_fsm.sv */
/*
 * Compute unit enable sequencer
 * Registers the enable level and the configuration word, holds the
 * first nonzero configuration and decodes its opcode and abort
 * fields. Commands may issue only once the unit is active
 */

`timescale 1ns/100ps

module cu_enable_fsm (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic                             enabled_in,
	input  logic [graph_cu_pkg::CFG_W-1:0]   cu_configure,
	output logic                             datapath_enable,
	output logic                             issue_enable,
	output graph_cu_pkg::cmd_opcode_t        cfg_opcode,
	output graph_cu_pkg::abort_type_t        cfg_abt
);

	import graph_cu_pkg::*;

	cu_state_t        state;
	logic             enabled_r;
	logic [CFG_W-1:0] cfg_r;
	logic [CFG_W-1:0] cfg_latched;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_r   <= 1'b0;
			cfg_r       <= '0;
			cfg_latched <= '0;
			cfg_opcode  <= READ_CL_NA;
			cfg_abt     <= ABT_STRICT;
		end else begin
			enabled_r <= enabled_in;
			cfg_r     <= cu_configure;
			// A disable releases the held word for the next run
			if (!enabled_r) begin
				cfg_latched <= '0;
			end else if (cfg_latched == '0 && cfg_r != '0) begin
				cfg_latched <= cfg_r;
				cfg_opcode  <= cfg_r[CFG_SHARED_BIT] ? READ_CL_S : READ_CL_NA;
				cfg_abt     <= map_abort(cfg_r[CFG_ABT_LSB +: 3]);
			end
		end
	end

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= CU_DISABLED;
		end else begin
			case (state)
				CU_DISABLED:
					if (enabled_r)
						state <= CU_WAIT_CONFIG;
				CU_WAIT_CONFIG:
					if (!enabled_r)
						state <= CU_DISABLED;
					else if (cfg_latched != '0)
						state <= CU_ACTIVE;
				CU_ACTIVE:
					if (!enabled_r)
						state <= CU_DISABLED;
				default:
					state <= CU_DISABLED;
			endcase
		end
	end

	assign datapath_enable = (state != CU_DISABLED);
	assign issue_enable    = (state == CU_ACTIVE);

endmodule

/* hdl/read_credit_counter.sv */
/*
 * Read credit counter
 * Tracks read commands whose data has not yet returned and flags
 * when another command may be granted
 */

`timescale 1ns/100ps

module read_credit_counter #(
	parameter int MAX_OUTSTANDING = 8
) (
	input  logic clock,
	input  logic rstn,
	input  logic command_issued,
	input  logic data_returned,
	output logic credit_available
);

	localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(MAX_OUTSTANDING);

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	// Saturates at both ends
	always_comb begin
		count_next = count;
		if (command_issued && !data_returned && count < LIMIT)
			count_next = count + 1'b1;
		else if (data_returned && !command_issued && count != '0)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count            <= '0;
			credit_available <= 1'b1;
		end else begin
			count            <= count_next;
			credit_available <= (count_next < LIMIT);
		end
	end

endmodule

/* hdl/edge_read_command_control.sv */
/*
 * Edge data read command control
 * Buffers edge jobs, turns each destination vertex into a cache
 * line read command, queues the commands for the bus with a
 * request/grant pair and buffers returned edge data until the
 * consumer pops it
 */

`timescale 1ns/100ps

module edge_read_command_control #(
	parameter int BUFFER_DEPTH   = 16,
	parameter int DATA_SIZE_READ = 4
) (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   datapath_enable,
	input  logic                                   issue_enable,
	input  graph_cu_pkg::cmd_opcode_t              cfg_opcode,
	input  graph_cu_pkg::abort_type_t              cfg_abt,
	input  logic                                   credit_available,
	input  logic                                   wed_valid,
	input  logic [graph_cu_pkg::ADDR_W-1:0]        wed_data_base,
	input  logic                                   edge_job_valid,
	input  logic [graph_cu_pkg::VERTEX_W-1:0]      edge_job_dest,
	input  logic                                   read_buffer_alfull,
	input  logic                                   read_command_bus_grant,
	input  logic                                   edge_data_read_valid,
	input  logic [graph_cu_pkg::DATA_W-1:0]        edge_data_read_value,
	input  logic                                   edge_data_request,
	output logic                                   edge_request,
	output logic                                   command_issued,
	output logic                                   read_command_bus_request,
	output logic                                   read_command_valid,
	output logic [graph_cu_pkg::ADDR_W-1:0]        read_command_address,
	output logic [graph_cu_pkg::CL_OFFSET_W-1:0]   read_command_offset,
	output graph_cu_pkg::cmd_opcode_t              read_command_opcode,
	output graph_cu_pkg::abort_type_t              read_command_abt,
	output logic                                   edge_data_valid,
	output logic [graph_cu_pkg::DATA_W-1:0]        edge_data_value,
	output logic                                   data_buffer_empty,
	output logic                                   data_buffer_full,
	output logic                                   data_buffer_alfull
);

	import graph_cu_pkg::*;

	localparam int SIZE_SHIFT = $clog2(DATA_SIZE_READ);
	localparam int OP_W       = $bits(cmd_opcode_t);
	localparam int ABT_W      = $bits(abort_type_t);
	localparam int CMD_W      = OP_W + ABT_W + CL_OFFSET_W + ADDR_W;
	localparam logic [ADDR_W-1:0] LINE_MASK = ADDR_W'(CACHELINE_BYTES - 1);

	logic                   edge_job_valid_r;
	logic [VERTEX_W-1:0]    edge_job_dest_r;
	logic                   wed_valid_r;
	logic [ADDR_W-1:0]      wed_data_base_r;
	logic                   grant_r;
	logic                   data_read_valid_r;
	logic [DATA_W-1:0]      data_read_value_r;
	logic                   data_request_r;

	logic                   job_pop;
	logic                   job_valid;
	logic [VERTEX_W-1:0]    job_dest;
	logic                   job_alfull;
	logic                   job_empty;

	logic [ADDR_W-1:0]      byte_offset;
	logic [ADDR_W-1:0]      build_address;
	logic [CL_OFFSET_W-1:0] build_offset;
	logic [CMD_W-1:0]       cmd_in;
	logic [CMD_W-1:0]       cmd_out;
	logic                   cmd_valid;
	logic                   cmd_alfull;
	logic                   cmd_empty;

	////////////////////
	// Input registers
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_job_valid_r  <= 1'b0;
			wed_valid_r       <= 1'b0;
			grant_r           <= 1'b0;
			data_read_valid_r <= 1'b0;
			data_request_r    <= 1'b0;
			edge_request      <= 1'b0;
		end else begin
			edge_job_valid_r  <= datapath_enable && edge_job_valid;
			wed_valid_r       <= datapath_enable && wed_valid;
			data_read_valid_r <= datapath_enable && edge_data_read_valid;
			data_request_r    <= datapath_enable && edge_data_request;
			edge_request      <= datapath_enable && !job_alfull;
			// Grant counts only with credit left and the memory side ready
			grant_r <= issue_enable && read_command_bus_grant && !read_buffer_alfull &&
				credit_available;
		end
	end

	always_ff @(posedge clock) begin
		edge_job_dest_r   <= edge_job_dest;
		wed_data_base_r   <= wed_data_base;
		data_read_value_r <= edge_data_read_value;
	end

	////////////////////
	// Job buffer and command builder
	////////////////////

	assign job_pop = !job_empty && !cmd_alfull && wed_valid_r && issue_enable;

	edge_fifo #(
		.WIDTH(VERTEX_W),
		.DEPTH(BUFFER_DEPTH)
	) u_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_job_valid_r),
		.data_in (edge_job_dest_r),
		.pop     (job_pop),
		.data_out(job_dest),
		.valid   (job_valid),
		.full    (),
		.alfull  (job_alfull),
		.empty   (job_empty)
	);

	// Line aligned address plus entry index inside the line
	always_comb begin
		byte_offset   = ADDR_W'(job_dest) << SIZE_SHIFT;
		build_address = wed_data_base_r + (byte_offset & ~LINE_MASK);
		build_offset  = byte_offset[CL_OFFSET_W-1:0] >> SIZE_SHIFT;
	end

	assign cmd_in = {cfg_opcode, cfg_abt, build_offset, build_address};

	////////////////////
	// Command buffer and bus arbitration
	////////////////////

	edge_fifo #(
		.WIDTH(CMD_W),
		.DEPTH(BUFFER_DEPTH)
	) u_cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid),
		.data_in (cmd_in),
		.pop     (grant_r),
		.data_out(cmd_out),
		.valid   (cmd_valid),
		.full    (),
		.alfull  (cmd_alfull),
		.empty   (cmd_empty)
	);

	// Request drops while a granted pop is still in flight
	assign read_command_bus_request = issue_enable && !cmd_empty && !read_buffer_alfull &&
		!grant_r;
	assign command_issued = grant_r;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			read_command_valid <= 1'b0;
		else
			read_command_valid <= cmd_valid;
	end

	always_ff @(posedge clock) begin
		if (cmd_valid) begin
			read_command_address <= cmd_out[ADDR_W-1:0];
			read_command_offset  <= cmd_out[ADDR_W +: CL_OFFSET_W];
			read_command_abt     <= abort_type_t'(cmd_out[ADDR_W + CL_OFFSET_W +: ABT_W]);
			read_command_opcode  <= cmd_opcode_t'(cmd_out[CMD_W-1 -: OP_W]);
		end
	end

	////////////////////
	// Edge data buffer
	////////////////////

	edge_fifo #(
		.WIDTH(DATA_W),
		.DEPTH(BUFFER_DEPTH)
	) u_data_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (data_read_valid_r),
		.data_in (data_read_value_r),
		.pop     (data_request_r),
		.data_out(edge_data_value),
		.valid   (edge_data_valid),
		.full    (data_buffer_full),
		.alfull  (data_buffer_alfull),
		.empty   (data_buffer_empty)
	);

endmodule

/* hdl/edge_read_top.sv */
/*
 * Edge-data read stage
 * Enable sequencer, read credit counter and command control of
 * one graph-processing compute unit
 */

`timescale 1ns/100ps

module edge_read_top #(
	parameter int BUFFER_DEPTH    = 16,
	parameter int DATA_SIZE_READ  = 4,
	parameter int MAX_OUTSTANDING = 8
) (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   enabled_in,
	input  logic [graph_cu_pkg::CFG_W-1:0]         cu_configure,
	input  logic                                   wed_valid,
	input  logic [graph_cu_pkg::ADDR_W-1:0]        wed_data_base,
	input  logic                                   edge_job_valid,
	input  logic [graph_cu_pkg::VERTEX_W-1:0]      edge_job_dest,
	input  logic                                   read_buffer_alfull,
	input  logic                                   read_command_bus_grant,
	input  logic                                   edge_data_read_valid,
	input  logic [graph_cu_pkg::DATA_W-1:0]        edge_data_read_value,
	input  logic                                   edge_data_request,
	output logic                                   edge_request,
	output logic                                   read_command_bus_request,
	output logic                                   read_command_valid,
	output logic [graph_cu_pkg::ADDR_W-1:0]        read_command_address,
	output logic [graph_cu_pkg::CL_OFFSET_W-1:0]   read_command_offset,
	output graph_cu_pkg::cmd_opcode_t              read_command_opcode,
	output graph_cu_pkg::abort_type_t              read_command_abt,
	output logic                                   edge_data_valid,
	output logic [graph_cu_pkg::DATA_W-1:0]        edge_data_value,
	output logic                                   data_buffer_empty,
	output logic                                   data_buffer_full,
	output logic                                   data_buffer_alfull
);

	logic                      datapath_enable;
	logic                      issue_enable;
	graph_cu_pkg::cmd_opcode_t cfg_opcode;
	graph_cu_pkg::abort_type_t cfg_abt;
	logic                      credit_available;
	logic                      command_issued;

	cu_enable_fsm u_enable_fsm (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.cu_configure   (cu_configure),
		.datapath_enable(datapath_enable),
		.issue_enable   (issue_enable),
		.cfg_opcode     (cfg_opcode),
		.cfg_abt        (cfg_abt)
	);

	// Each returned word frees one credit
	read_credit_counter #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) u_credit_counter (
		.clock           (clock),
		.rstn            (rstn),
		.command_issued  (command_issued),
		.data_returned   (edge_data_read_valid),
		.credit_available(credit_available)
	);

	edge_read_command_control #(
		.BUFFER_DEPTH  (BUFFER_DEPTH),
		.DATA_SIZE_READ(DATA_SIZE_READ)
	) u_command_control (
		.clock                   (clock),
		.rstn                    (rstn),
		.datapath_enable         (datapath_enable),
		.issue_enable            (issue_enable),
		.cfg_opcode              (cfg_opcode),
		.cfg_abt                 (cfg_abt),
		.credit_available        (credit_available),
		.wed_valid               (wed_valid),
		.wed_data_base           (wed_data_base),
		.edge_job_valid          (edge_job_valid),
		.edge_job_dest           (edge_job_dest),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_grant  (read_command_bus_grant),
		.edge_data_read_valid    (edge_data_read_valid),
		.edge_data_read_value    (edge_data_read_value),
		.edge_data_request       (edge_data_request),
		.edge_request            (edge_request),
		.command_issued          (command_issued),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_address    (read_command_address),
		.read_command_offset     (read_command_offset),
		.read_command_opcode     (read_command_opcode),
		.read_command_abt        (read_command_abt),
		.edge_data_valid         (edge_data_valid),
		.edge_data_value         (edge_data_value),
		.data_buffer_empty       (data_buffer_empty),
		.data_buffer_full        (data_buffer_full),
		.data_buffer_alfull      (data_buffer_alfull)
	);

endmodule

/* bench/tb_clock_gen.sv */
/*
 * Bench clock and reset
 * Free running clock and an active low reset held for a
 * number of clock cycles at the start of the run
 */

`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Release lands on a falling edge
	initial begin
		rstn = 1'b0;
		#(PERIOD * RESET_CYCLES);
		rstn = 1'b1;
	end

endmodule

/* bench/edge_read_props.sv */
/*
 * Edge-data read stage properties
 * Bound to the top level. Checks the read credit bound, the bus
 * request under memory back pressure and room in the data buffer
 */

`timescale 1ns/100ps

module edge_read_props #(
	parameter int MAX_OUTSTANDING = 8
) (
	input logic clock,
	input logic rstn,
	input logic read_buffer_alfull,
	input logic read_command_bus_request,
	input logic command_issued,
	input logic edge_data_read_valid,
	input logic data_buffer_full
);

	// Raised by any failing property below
	logic violation;
	int   in_flight;

	initial violation = 1'b0;

	// Commands granted but not yet answered by data
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(command_issued) - int'(edge_data_read_valid);
	end

	credit_bound: assert property (@(posedge clock) disable iff (!rstn)
		in_flight >= 0 && in_flight <= MAX_OUTSTANDING)
	else begin
		violation = 1'b1;
		$error("In-flight read count %0d outside 0..%0d", in_flight, MAX_OUTSTANDING);
	end

	request_blocked: assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_alfull && $past(read_buffer_alfull) |-> !read_command_bus_request)
	else begin
		violation = 1'b1;
		$error("Bus request high under sustained read buffer back pressure");
	end

	grant_blocked: assert property (@(posedge clock) disable iff (!rstn)
		read_buffer_alfull |=> !command_issued)
	else begin
		violation = 1'b1;
		$error("Grant accepted while read buffer was almost full");
	end

	// Returned word is pushed one cycle after its strobe
	data_room: assert property (@(posedge clock) disable iff (!rstn)
		edge_data_read_valid |=> !data_buffer_full)
	else begin
		violation = 1'b1;
		$error("Data buffer full while a returned word was pushed");
	end

endmodule

/* bench/tb_edge_read.sv */
/*
 * Edge-data read stage testbench
 * Drives edge jobs, bus grants, back pressure and returned data
 * with random timing, and checks commands and popped data against
 * queues of expected values built from the address rule
 */

`timescale 1ns/100ps

module tb_edge_read;

	import graph_cu_pkg::*;

	localparam int DATA_SIZE_READ  = 4;
	localparam int MAX_OUTSTANDING = 8;
	localparam int NUM_JOBS        = 40;
	localparam logic [CFG_W-1:0]  CFG_A  = 64'h0000_00ff_0000_2801;
	localparam logic [CFG_W-1:0]  CFG_B  = 64'h0000_0000_0300_1805;
	localparam logic [ADDR_W-1:0] BASE_A = 64'h0000_0040_2000_0a40;
	localparam logic [ADDR_W-1:0] BASE_B = 64'h0000_0071_8000_0000;

	logic                   clock;
	logic                   rstn;
	logic                   enabled_in;
	logic [CFG_W-1:0]       cu_configure;
	logic                   wed_valid;
	logic [ADDR_W-1:0]      wed_data_base;
	logic                   edge_job_valid;
	logic [VERTEX_W-1:0]    edge_job_dest;
	logic                   read_buffer_alfull;
	logic                   read_command_bus_grant;
	logic                   edge_data_read_valid;
	logic [DATA_W-1:0]      edge_data_read_value;
	logic                   edge_data_request;
	logic                   edge_request;
	logic                   read_command_bus_request;
	logic                   read_command_valid;
	logic [ADDR_W-1:0]      read_command_address;
	logic [CL_OFFSET_W-1:0] read_command_offset;
	cmd_opcode_t            read_command_opcode;
	abort_type_t            read_command_abt;
	logic                   edge_data_valid;
	logic [DATA_W-1:0]      edge_data_value;
	logic                   data_buffer_empty;
	logic                   data_buffer_full;
	logic                   data_buffer_alfull;

	integer           seed;
	int               jobs_left;
	int               job_gap;
	int               pending_returns;
	bit               ignore_ready;
	bit               record_jobs;
	bit               force_grants;
	bit               issue_allowed;
	logic [CFG_W-1:0] cur_cfg;
	logic [ADDR_W-1:0] cur_base;

	// Expected commands and data in arrival order
	logic [ADDR_W-1:0]      exp_addr [$];
	logic [CL_OFFSET_W-1:0] exp_off [$];
	cmd_opcode_t            exp_op [$];
	abort_type_t            exp_abt [$];
	logic [DATA_W-1:0]      exp_data [$];

	tb_clock_gen #(
		.PERIOD      (40),
		.RESET_CYCLES(3)
	) u_clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	edge_read_top #(
		.BUFFER_DEPTH   (16),
		.DATA_SIZE_READ (DATA_SIZE_READ),
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) u_dut (
		.clock                   (clock),
		.rstn                    (rstn),
		.enabled_in              (enabled_in),
		.cu_configure            (cu_configure),
		.wed_valid               (wed_valid),
		.wed_data_base           (wed_data_base),
		.edge_job_valid          (edge_job_valid),
		.edge_job_dest           (edge_job_dest),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_grant  (read_command_bus_grant),
		.edge_data_read_valid    (edge_data_read_valid),
		.edge_data_read_value    (edge_data_read_value),
		.edge_data_request       (edge_data_request),
		.edge_request            (edge_request),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid),
		.read_command_address    (read_command_address),
		.read_command_offset     (read_command_offset),
		.read_command_opcode     (read_command_opcode),
		.read_command_abt        (read_command_abt),
		.edge_data_valid         (edge_data_valid),
		.edge_data_value         (edge_data_value),
		.data_buffer_empty       (data_buffer_empty),
		.data_buffer_full        (data_buffer_full),
		.data_buffer_alfull      (data_buffer_alfull)
	);

	bind edge_read_top edge_read_props #(
		.MAX_OUTSTANDING(MAX_OUTSTANDING)
	) u_props (
		.clock                   (clock),
		.rstn                    (rstn),
		.read_buffer_alfull      (read_buffer_alfull),
		.read_command_bus_request(read_command_bus_request),
		.command_issued          (command_issued),
		.edge_data_read_valid    (edge_data_read_valid),
		.data_buffer_full        (data_buffer_full)
	);

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		assert (got == expected) else begin
			$display("[FAIL] %s got %h expected %h", name, got, expected);
			stop_on_error();
		end
	endtask

	function automatic cmd_opcode_t expected_opcode(input logic [CFG_W-1:0] cfg);
		return cfg[CFG_SHARED_BIT] ? READ_CL_S : READ_CL_NA;
	endfunction

	// Codes above 4 are not defined and read as strict
	function automatic abort_type_t expected_abort(input logic [CFG_W-1:0] cfg);
		logic [2:0] code;
		code = cfg[CFG_ABT_LSB +: 3];
		return (code > 3'd4) ? ABT_STRICT : abort_type_t'(code);
	endfunction

	task automatic queue_job(input logic [VERTEX_W-1:0] dest);
		logic [ADDR_W-1:0] byte_off;
		byte_off = ADDR_W'(dest) * DATA_SIZE_READ;
		exp_addr.push_back(cur_base + (byte_off / CACHELINE_BYTES) * CACHELINE_BYTES);
		exp_off.push_back(CL_OFFSET_W'((byte_off % CACHELINE_BYTES) / DATA_SIZE_READ));
		exp_op.push_back(expected_opcode(cur_cfg));
		exp_abt.push_back(expected_abort(cur_cfg));
	endtask

	////////////////////
	// Stimulus per falling edge
	////////////////////

	task automatic run_cycle();
		logic [31:0] r;
		@(negedge clock);
		r = $random(seed);
		// Back pressure may rise together with a grant
		if ((read_command_bus_request || force_grants) && r[1:0] != 2'b00) begin
			read_command_bus_grant = 1'b1;
			read_buffer_alfull     = (r[5:3] == 3'b000);
		end else begin
			read_command_bus_grant = 1'b0;
			read_buffer_alfull     = read_buffer_alfull ? r[2] : (r[5:3] == 3'b000);
		end
		// Slow returns let the in-flight count reach the credit limit
		edge_data_read_valid = 1'b0;
		if (pending_returns > 0 && !data_buffer_alfull && r[6] && r[10] && r[11]) begin
			edge_data_read_valid = 1'b1;
			edge_data_read_value = $random(seed);
			exp_data.push_back(edge_data_read_value);
			pending_returns--;
		end
		edge_data_request = !data_buffer_empty && !edge_data_request && r[7];
		// Gap after each job lets edge_request catch up
		edge_job_valid = 1'b0;
		if (job_gap > 0) begin
			job_gap--;
		end else if (jobs_left > 0 && (edge_request || ignore_ready)) begin
			edge_job_valid = 1'b1;
			edge_job_dest  = $random(seed);
			if (record_jobs)
				queue_job(edge_job_dest);
			jobs_left--;
			job_gap = 3 + int'(r[9:8]);
		end
	endtask

	task automatic run_until_drained();
		while (jobs_left > 0 || exp_addr.size() > 0 || pending_returns > 0 ||
			exp_data.size() > 0)
			run_cycle();
	endtask

	////////////////////
	// Checkers
	////////////////////

	always @(posedge clock) begin : output_monitor
		if (rstn && read_command_valid) begin
			assert (issue_allowed && exp_addr.size() > 0) else begin
				$display("Read command issued while none was expected");
				stop_on_error();
			end
			check_value("read_command_address", read_command_address, exp_addr.pop_front());
			check_value("read_command_offset", read_command_offset, exp_off.pop_front());
			check_value("read_command_opcode", read_command_opcode, exp_op.pop_front());
			check_value("read_command_abt", read_command_abt, exp_abt.pop_front());
			pending_returns++;
		end
		if (rstn && edge_data_valid) begin
			assert (exp_data.size() > 0) else begin
				$display("Edge data word popped while none was expected");
				stop_on_error();
			end
			check_value("edge_data_value", edge_data_value, exp_data.pop_front());
		end
	end

	initial begin : props_watch
		wait (u_dut.u_props.violation);
		$display("A bound property assertion failed");
		stop_on_error();
	end

	initial begin : watchdog
		repeat (NUM_JOBS * 50) @(posedge clock);
		$display("Timeout after %0d cycles without finishing", NUM_JOBS * 50);
		stop_on_error();
	end

	initial begin : main_sequence
		seed                   = 32'h1f037d0a;
		enabled_in             = 1'b0;
		cu_configure           = '0;
		wed_valid              = 1'b0;
		wed_data_base          = '0;
		edge_job_valid         = 1'b0;
		edge_job_dest          = '0;
		read_buffer_alfull     = 1'b0;
		read_command_bus_grant = 1'b0;
		edge_data_read_valid   = 1'b0;
		edge_data_read_value   = '0;
		edge_data_request      = 1'b0;
		jobs_left              = 0;
		job_gap                = 0;
		pending_returns        = 0;
		ignore_ready           = 1'b0;
		record_jobs            = 1'b0;
		force_grants           = 1'b0;
		issue_allowed          = 1'b0;
		cur_cfg                = CFG_A;
		cur_base               = BASE_A;

		wait (rstn);
		@(negedge clock);
		check_value("read_command_valid", read_command_valid, 1'b0);
		check_value("edge_data_valid", edge_data_valid, 1'b0);
		check_value("read_command_bus_request", read_command_bus_request, 1'b0);
		check_value("edge_request", edge_request, 1'b0);
		check_value("data_buffer_empty", data_buffer_empty, 1'b1);
		check_value("data_buffer_full", data_buffer_full, 1'b0);
		check_value("data_buffer_alfull", data_buffer_alfull, 1'b0);

		// Jobs and grants go nowhere while the unit is disabled
		wed_valid     = 1'b1;
		wed_data_base = BASE_A;
		cu_configure  = CFG_A;
		ignore_ready  = 1'b1;
		force_grants  = 1'b1;
		jobs_left     = 4;
		while (jobs_left > 0)
			run_cycle();
		repeat (8) run_cycle();

		// Jobs wait in the buffer until a configuration arrives
		enabled_in   = 1'b1;
		cu_configure = '0;
		while (!edge_request)
			run_cycle();
		ignore_ready = 1'b0;
		record_jobs  = 1'b1;
		jobs_left    = 4;
		while (jobs_left > 0)
			run_cycle();
		repeat (10) run_cycle();

		// First run phase
		cu_configure  = CFG_A;
		issue_allowed = 1'b1;
		force_grants  = 1'b0;
		jobs_left     = 16;
		run_until_drained();

		enabled_in    = 1'b0;
		cu_configure  = '0;
		issue_allowed = 1'b0;
		while (edge_request)
			run_cycle();
		repeat (4) run_cycle();

		// Second run phase with a new base and configuration
		cur_base      = BASE_B;
		cur_cfg       = CFG_B;
		wed_data_base = BASE_B;
		cu_configure  = CFG_B;
		enabled_in    = 1'b1;
		issue_allowed = 1'b1;
		jobs_left     = 20;
		run_until_drained();
		repeat (10) run_cycle();

		if (u_dut.u_props.violation || exp_addr.size() != 0 || exp_data.size() != 0) begin
			$display("Expected commands or data left over at the end of the run");
			stop_on_error();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

/* edge_read_top.f */
hdl/graph_cu_pkg.sv
hdl/edge_fifo.sv
hdl/cu_enable_fsm.sv
hdl/read_credit_counter.sv
hdl/edge_read_command_control.sv
hdl/edge_read_top.sv
bench/tb_clock_gen.sv
bench/edge_read_props.sv
bench/tb_edge_read.sv

/* Bender.yml */
package:
  name: edge_read

sources:
  - hdl/graph_cu_pkg.sv
  - hdl/edge_fifo.sv
  - hdl/cu_enable_fsm.sv
  - hdl/read_credit_counter.sv
  - hdl/edge_read_command_control.sv
  - hdl/edge_read_top.sv
  - target: simulation
    files:
      - bench/tb_clock_gen.sv
      - bench/edge_read_props.sv
      - bench/tb_edge_read.sv
